/* compile.f */
rtl/cache_pkg.sv
rtl/cache_way_ram.sv
rtl/cache_req_decode.sv
rtl/cache_lookup.sv
rtl/cache_store_buffer.sv
rtl/cache_resp.sv
rtl/cache_top.sv
sim/cache_sva.sv
sim/tb_cache.sv

/* sim/cache_patterns.txt */
# columns: op addr wstrb wdata expect hit, all hex (op 1 = store, store rows ignore expect)
# hit 1 means o_data_ok must follow the accept by exactly one cycle
0 00001000 00 0000000000000000 00001000ffffefff 0
0 00001008 00 0000000000000000 00001008ffffeff7 1
0 00001010 00 0000000000000000 00001010ffffefef 1
0 00001018 00 0000000000000000 00001018ffffefe7 1
1 00001008 0f 1122334455667788 0000000000000000 1
0 00001008 00 0000000000000000 0000100855667788 1
1 00001010 f0 aabbccdd00000000 0000000000000000 1
0 00001018 00 0000000000000000 00001018ffffefe7 1
0 00001010 00 0000000000000000 aabbccddffffefef 1
0 00001800 00 0000000000000000 00001800ffffe7ff 0
0 00002000 00 0000000000000000 00002000ffffdfff 0
0 00001008 00 0000000000000000 0000100855667788 0
0 00001010 00 0000000000000000 aabbccddffffefef 1
1 00001800 ff 0123456789abcdef 0000000000000000 0
0 00001800 00 0000000000000000 0123456789abcdef 1
0 00002008 00 0000000000000000 00002008ffffdff7 0
0 00003000 00 0000000000000000 00003000ffffcfff 0
0 00001818 00 0000000000000000 00001818ffffe7e7 0
0 00001800 00 0000000000000000 0123456789abcdef 1
0 0000a0e8 00 0000000000000000 0000a0e8ffff5f17 0
0 0000a0e0 00 0000000000000000 0000a0e0ffff5f1f 1
1 0000a0f0 81 ee000000000000dd 0000000000000000 1
0 0000a0f0 00 0000000000000000 ee00a0f0ffff5fdd 1
0 7ffffff8 00 0000000000000000 7ffffff880000007 0
0 7fffffe0 00 0000000000000000 7fffffe08000001f 1

/* sim/tb_cache.sv */
// Data cache testbench
module tb_cache;

  typedef struct packed {
    logic                         op;
    logic [cache_pkg::ADDR_W-1:0] addr;
    logic [cache_pkg::STRB_W-1:0] strb;
    logic [cache_pkg::WORD_W-1:0] wdata;
    logic [cache_pkg::WORD_W-1:0] expect_word;
    logic                         hit;        // one-cycle latency expected
  } pattern_t;

  typedef struct packed {
    pattern_t    pat;
    logic [31:0] cycle;                       // accept cycle
  } pending_t;

  logic                         i_clk;
  logic                         i_rst;
  logic                         i_valid;
  logic                         i_op;
  logic [cache_pkg::ADDR_W-1:0] i_addr;
  logic [cache_pkg::STRB_W-1:0] i_wstrb;
  logic [cache_pkg::WORD_W-1:0] i_wdata;
  logic                         o_addr_ok;
  logic                         o_data_ok;
  logic [cache_pkg::WORD_W-1:0] o_rdata;
  logic                         o_rd_req;
  logic [cache_pkg::ADDR_W-1:0] o_rd_addr;
  logic                         i_rd_rdy;
  logic                         i_ret_valid;
  logic                         i_ret_last;
  logic [cache_pkg::WORD_W-1:0] i_ret_data;
  logic                         o_wr_req;
  logic [cache_pkg::ADDR_W-1:0] o_wr_addr;
  cache_pkg::line_t             o_wr_data;
  logic                         i_wr_rdy;

  logic [cache_pkg::WORD_W-1:0] mem [logic [cache_pkg::ADDR_W-1:0]];
  pattern_t                     pats[$];
  pending_t                     pend[$];
  pattern_t                     cur_pat;
  logic                         loaded = 1'b0;
  logic [31:0]                  cycle_cnt = '0;
  integer                       seed = 32'h7711_0bec;
  int                           rdata_errors = 0;
  int                           latency_errors = 0;
  int                           protocol_errors = 0;

  cache_top u_dut (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_valid     (i_valid),
    .i_op        (i_op),
    .i_addr      (i_addr),
    .i_wstrb     (i_wstrb),
    .i_wdata     (i_wdata),
    .o_addr_ok   (o_addr_ok),
    .o_data_ok   (o_data_ok),
    .o_rdata     (o_rdata),
    .o_rd_req    (o_rd_req),
    .o_rd_addr   (o_rd_addr),
    .i_rd_rdy    (i_rd_rdy),
    .i_ret_valid (i_ret_valid),
    .i_ret_last  (i_ret_last),
    .i_ret_data  (i_ret_data),
    .o_wr_req    (o_wr_req),
    .o_wr_addr   (o_wr_addr),
    .o_wr_data   (o_wr_data),
    .i_wr_rdy    (i_wr_rdy)
  );

  always #4 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle_cnt <= cycle_cnt + 32'd1;
  end

  // unwritten words read as {A, ~A}
  function automatic logic [cache_pkg::WORD_W-1:0] mem_word(input logic [31:0] addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return {addr, ~addr};
  endfunction

  task automatic check_level(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("Fail %s after reset: got %h expected %h", name, got, want);
      protocol_errors++;
    end
  endtask

  // hold the request until the cache takes it
  task automatic issue(input pattern_t p);
    logic took;
    cur_pat = p;
    i_valid = 1'b1;
    i_op    = p.op;
    i_addr  = p.addr;
    i_wstrb = p.strb;
    i_wdata = p.wdata;
    took    = 1'b0;
    while (!took) begin
      @(negedge i_clk);
      took = o_addr_ok;
      @(posedge i_clk);
      #1;
    end
    i_valid = 1'b0;
  endtask

  // ------------------------------------------------------------
  // response checker, sampled mid-cycle
  always @(negedge i_clk) begin
    pending_t e;
    if (!i_rst) begin
      if (o_data_ok) begin
        if (pend.size() == 0) begin
          $display("o_data_ok pulsed with no request outstanding at cycle %0d", cycle_cnt);
          protocol_errors++;
        end else begin
          e = pend.pop_front();
          if (!e.pat.op && (o_rdata !== e.pat.expect_word)) begin
            $display("Fail o_rdata at %h: got %h expected %h",
                     e.pat.addr, o_rdata, e.pat.expect_word);
            rdata_errors++;
          end
          if (e.pat.hit && (cycle_cnt != e.cycle + 32'd1)) begin
            $display("Hit at %h answered %0d cycles after accept instead of 1",
                     e.pat.addr, cycle_cnt - e.cycle);
            latency_errors++;
          end
        end
      end
      if (i_valid && o_addr_ok) begin
        e.pat   = cur_pat;
        e.cycle = cycle_cnt;
        pend.push_back(e);
      end
    end
  end

  // ------------------------------------------------------------
  // memory bus model
  initial begin : mem_read
    logic [31:0] base;
    logic [31:0] want;
    int          delay;
    i_rd_rdy    = 1'b0;
    i_ret_valid = 1'b0;
    i_ret_last  = 1'b0;
    i_ret_data  = '0;
    forever begin
      @(negedge i_clk);
      if (!i_rst && o_rd_req) begin
        base = o_rd_addr;
        if (pend.size() != 1) begin
          $display("Line read requested with %0d requests outstanding instead of 1",
                   pend.size());
          protocol_errors++;
        end else begin
          want = pend[0].pat.addr & ~32'h1f;          // 32-byte line base
          if (o_rd_addr !== want) begin
            $display("Fail o_rd_addr: got %h expected %h", o_rd_addr, want);
            protocol_errors++;
          end
        end
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(posedge i_clk);
        @(posedge i_clk);
        #1;
        i_rd_rdy = 1'b1;
        @(posedge i_clk);
        #1;
        i_rd_rdy = 1'b0;
        for (int b = 0; b < cache_pkg::WORDS_PER_LINE; b++) begin
          i_ret_valid = 1'b1;
          i_ret_last  = (b == cache_pkg::WORDS_PER_LINE - 1);
          i_ret_data  = mem_word(base + 32'(8 * b));   // ascending words
          @(posedge i_clk);
          #1;
        end
        i_ret_valid = 1'b0;
        i_ret_last  = 1'b0;
      end
    end
  end

  initial begin : wr_ready
    i_wr_rdy = 1'b1;
    forever begin
      @(posedge i_clk);
      #1;
      if (!i_wr_rdy) begin
        i_wr_rdy = 1'b1;                      // drops last one cycle
      end else begin
        i_wr_rdy = ($unsigned($random(seed)) % 4) != 0;
      end
    end
  end

  always @(negedge i_clk) begin
    if (!i_rst && o_wr_req) begin
      for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
        mem[o_wr_addr + 32'(8 * w)] = o_wr_data[w*cache_pkg::WORD_W +: cache_pkg::WORD_W];
      end
    end
  end

  initial begin : watchdog
    int limit;
    wait (loaded);
    limit = pats.size() * 40 + 200;
    repeat (limit) @(posedge i_clk);
    $display("Timeout: run did not finish within %0d cycles", limit);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // ------------------------------------------------------------
  // main sequence
  initial begin : main_seq
    int          fd;
    int          total;
    string       text;
    pattern_t    p;
    logic [63:0] f_op;
    logic [63:0] f_addr;
    logic [63:0] f_strb;
    logic [63:0] f_wdata;
    logic [63:0] f_exp;
    logic [63:0] f_hit;
    i_clk   = 1'b0;
    i_rst   = 1'b1;
    i_valid = 1'b0;
    i_op    = 1'b0;
    i_addr  = '0;
    i_wstrb = '0;
    i_wdata = '0;
    fd = $fopen("sim/cache_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file sim/cache_patterns.txt");
      protocol_errors++;
    end else begin
      while (!$feof(fd)) begin
        text = "";
        void'($fgets(text, fd));
        if ((text.len() > 0) && (text.getc(0) != "#")) begin
          if ($sscanf(text, "%h %h %h %h %h %h",
                      f_op, f_addr, f_strb, f_wdata, f_exp, f_hit) == 6) begin
            p.op          = f_op[0];
            p.addr        = f_addr[cache_pkg::ADDR_W-1:0];
            p.strb        = f_strb[cache_pkg::STRB_W-1:0];
            p.wdata       = f_wdata;
            p.expect_word = f_exp;
            p.hit         = f_hit[0];
            pats.push_back(p);
          end
        end
      end
      $fclose(fd);
      if (pats.size() == 0) begin
        $display("The pattern file holds no requests");
        protocol_errors++;
      end
    end
    loaded = 1'b1;

    repeat (4) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    @(negedge i_clk);
    check_level("o_rd_req", o_rd_req, 1'b0);
    check_level("o_wr_req", o_wr_req, 1'b0);
    check_level("o_data_ok", o_data_ok, 1'b0);
    check_level("o_addr_ok", o_addr_ok, 1'b1);
    @(posedge i_clk);
    #1;

    foreach (pats[k]) begin
      issue(pats[k]);
    end
    while (pend.size() != 0) begin
      @(posedge i_clk);
    end
    repeat (4) @(posedge i_clk);
    @(negedge i_clk);

    total = rdata_errors + latency_errors + protocol_errors + u_dut.u_sva.sva_errors;
    $display("errors: rdata %0d, latency %0d, protocol %0d, assertion %0d",
             rdata_errors, latency_errors, protocol_errors, u_dut.u_sva.sva_errors);
    if (total == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* sim/cache_sva.sv */
// Cache bus and handshake assertions
module cache_sva (
  input logic                         i_clk,
  input logic                         i_rst,
  input logic                         i_valid,
  input logic                         o_addr_ok,
  input logic                         o_data_ok,
  input logic                         o_rd_req,
  input logic [cache_pkg::ADDR_W-1:0] o_rd_addr,
  input logic                         i_rd_rdy,
  input logic                         o_wr_req,
  input logic [cache_pkg::ADDR_W-1:0] o_wr_addr
);

  int         sva_errors = 0;
  logic [3:0] outstanding;                  // accepted, not yet answered

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      outstanding <= '0;
    end else begin
      outstanding <= outstanding + 4'(i_valid && o_addr_ok) - 4'(o_data_ok);
    end
  end

  a_rd_req_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_rd_req && !i_rd_rdy |=> o_rd_req && $stable(o_rd_addr))
    else begin
      sva_errors++;
      $error("o_rd_req or o_rd_addr changed before i_rd_rdy");
    end

  // victim goes out, then another line of the same set comes in
  a_wr_then_rd: assert property (@(posedge i_clk) disable iff (i_rst)
    o_wr_req |=> o_rd_req &&
      (o_rd_addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W] ==
       $past(o_wr_addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W])) &&
      (o_rd_addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W] !=
       $past(o_wr_addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W])))
    else begin
      sva_errors++;
      $error("writeback not followed by a refill of another line in the same set");
    end

  a_data_ok_owed: assert property (@(posedge i_clk) disable iff (i_rst)
    o_data_ok |-> outstanding != 4'd0)
    else begin
      sva_errors++;
      $error("o_data_ok with no outstanding request");
    end

endmodule

bind cache_top cache_sva u_sva (.*);

/* rtl/cache_top.sv */
// Two-way data cache top level
module cache_top (
  input  logic                         i_clk,
  input  logic                         i_rst,
  input  logic                         i_valid,
  input  logic                         i_op,
  input  logic [cache_pkg::ADDR_W-1:0] i_addr,
  input  logic [cache_pkg::STRB_W-1:0] i_wstrb,
  input  logic [cache_pkg::WORD_W-1:0] i_wdata,
  output logic                         o_addr_ok,
  output logic                         o_data_ok,
  output logic [cache_pkg::WORD_W-1:0] o_rdata,
  output logic                         o_rd_req,
  output logic [cache_pkg::ADDR_W-1:0] o_rd_addr,
  input  logic                         i_rd_rdy,
  input  logic                         i_ret_valid,
  input  logic                         i_ret_last,
  input  logic [cache_pkg::WORD_W-1:0] i_ret_data,
  output logic                         o_wr_req,
  output logic [cache_pkg::ADDR_W-1:0] o_wr_addr,
  output cache_pkg::line_t             o_wr_data,
  input  logic                         i_wr_rdy
);

  cache_pkg::cache_req_t                           req;
  cache_pkg::store_op_t                            store_now;
  cache_pkg::store_op_t                            store_held;
  cache_pkg::line_wr_t                             line_wr;
  cache_pkg::tag_entry_t [cache_pkg::NUM_WAYS-1:0] tag_rd;
  cache_pkg::line_t [cache_pkg::NUM_WAYS-1:0]      line_rd;
  cache_pkg::tag_entry_t                           tag_wdata;
  logic [cache_pkg::NUM_WAYS-1:0]                  tag_we;
  logic [cache_pkg::INDEX_W-1:0]                   in_index;
  logic [cache_pkg::INDEX_W-1:0]                   ram_index;
  logic [cache_pkg::INDEX_W-1:0]                   tag_windex;
  logic                                            conflict;
  logic                                            accept;
  logic                                            lookup;
  logic                                            hit;
  logic                                            hit_way;
  logic                                            refill_en;
  logic                                            refill_way;
  logic [1:0]                                      refill_beat;
  logic [cache_pkg::WORD_W-1:0]                    refill_data;

  assign in_index = i_addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];

  cache_req_decode u_decode (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_valid      (i_valid),
    .i_op         (i_op),
    .i_addr       (i_addr),
    .i_wstrb      (i_wstrb),
    .i_wdata      (i_wdata),
    .i_accept     (accept),
    .i_store_held (store_held),
    .i_store_now  (store_now),
    .o_conflict   (conflict),
    .o_req        (req)
  );

  cache_lookup u_lookup (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_valid       (i_valid),
    .i_conflict    (conflict),
    .i_req         (req),
    .i_in_index    (in_index),
    .i_tag_rd      (tag_rd),
    .i_line_rd     (line_rd),
    .i_rd_rdy      (i_rd_rdy),
    .i_ret_valid   (i_ret_valid),
    .i_ret_last    (i_ret_last),
    .i_ret_data    (i_ret_data),
    .i_wr_rdy      (i_wr_rdy),
    .o_accept      (accept),
    .o_addr_ok     (o_addr_ok),
    .o_ram_index   (ram_index),
    .o_tag_we      (tag_we),
    .o_tag_windex  (tag_windex),
    .o_tag_wdata   (tag_wdata),
    .o_lookup      (lookup),
    .o_hit         (hit),
    .o_hit_way     (hit_way),
    .o_store       (store_now),
    .o_refill_en   (refill_en),
    .o_refill_way  (refill_way),
    .o_refill_beat (refill_beat),
    .o_refill_data (refill_data),
    .o_rd_req      (o_rd_req),
    .o_rd_addr     (o_rd_addr),
    .o_wr_req      (o_wr_req),
    .o_wr_addr     (o_wr_addr),
    .o_wr_data     (o_wr_data)
  );

  cache_store_buffer u_store_buf (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_store        (store_now),
    .i_refill_en    (refill_en),
    .i_refill_way   (refill_way),
    .i_refill_index (req.index),
    .i_refill_beat  (refill_beat),
    .i_refill_data  (refill_data),
    .o_held         (store_held),
    .o_line_wr      (line_wr)
  );

  cache_resp u_resp (
    .i_hit     (hit),
    .i_hit_way (hit_way),
    .i_word    (req.offset[cache_pkg::OFFSET_W-1 -: 2]),
    .i_line_rd (line_rd),
    .i_lookup  (lookup),
    .o_data_ok (o_data_ok),
    .o_rdata   (o_rdata)
  );

  // ----------------------------------------------------------
  // tag and data storage, one pair per way
  for (genvar w = 0; w < cache_pkg::NUM_WAYS; w++) begin : g_way
    cache_way_ram #(
      .ENTRY_T (cache_pkg::tag_entry_t),
      .DEPTH   (cache_pkg::NUM_SETS)
    ) u_tag_ram (
      .i_clk   (i_clk),
      .i_we    (tag_we[w]),
      .i_waddr (tag_windex),
      .i_addr  (ram_index),
      .i_wmask ('1),                      // whole entry
      .i_wdata (tag_wdata),
      .o_rdata (tag_rd[w])
    );

    cache_way_ram #(
      .ENTRY_T (cache_pkg::line_t),
      .DEPTH   (cache_pkg::NUM_SETS)
    ) u_data_ram (
      .i_clk   (i_clk),
      .i_we    (line_wr.en && (line_wr.way == 1'(w))),
      .i_waddr (line_wr.index),
      .i_addr  (ram_index),
      .i_wmask (line_wr.mask),
      .i_wdata (line_wr.data),
      .o_rdata (line_rd[w])
    );
  end

endmodule

/* rtl/cache_resp.sv */
// Cache read response
module cache_resp (
  input  logic                                       i_hit,
  input  logic                                       i_hit_way,
  input  logic [1:0]                                 i_word,
  input  cache_pkg::line_t [cache_pkg::NUM_WAYS-1:0] i_line_rd,
  input  logic                                       i_lookup,
  output logic                                       o_data_ok,
  output logic [cache_pkg::WORD_W-1:0]               o_rdata
);

  cache_pkg::line_t hit_line;

  assign hit_line  = i_line_rd[i_hit_way];
  assign o_rdata   = hit_line[i_word * cache_pkg::WORD_W +: cache_pkg::WORD_W];
  assign o_data_ok = i_lookup && i_hit;       // reads and stores alike

endmodule

/* rtl/cache_store_buffer.sv */
// Store buffer and line write port
module cache_store_buffer (
  input  logic                          i_clk,
  input  logic                          i_rst,
  input  cache_pkg::store_op_t          i_store,
  input  logic                          i_refill_en,
  input  logic                          i_refill_way,
  input  logic [cache_pkg::INDEX_W-1:0] i_refill_index,
  input  logic [1:0]                    i_refill_beat,
  input  logic [cache_pkg::WORD_W-1:0]  i_refill_data,
  output cache_pkg::store_op_t          o_held,
  output cache_pkg::line_wr_t           o_line_wr
);

  logic [cache_pkg::WORD_W-1:0] strb_mask;
  logic [cache_pkg::WORD_W-1:0] word_mask;
  logic [cache_pkg::WORD_W-1:0] word_data;
  logic [1:0]                   word_sel;

  // reloaded every cycle, so chained store hits follow each other
  always_ff @(posedge i_clk) begin
    o_held <= i_store;
    if (i_rst) begin
      o_held.valid <= 1'b0;
    end
  end

  // byte strobe to bit mask
  always_comb begin
    for (int b = 0; b < cache_pkg::STRB_W; b++) begin
      strb_mask[b*8 +: 8] = {8{o_held.wstrb[b]}};
    end
  end

  // refill beat wins over held store
  assign word_sel  = i_refill_en ? i_refill_beat : o_held.word;
  assign word_mask = i_refill_en ? '1 : strb_mask;
  assign word_data = i_refill_en ? i_refill_data : o_held.wdata;

  assign o_line_wr = '{
    en:    i_refill_en || o_held.valid,
    way:   i_refill_en ? i_refill_way : o_held.way,
    index: i_refill_en ? i_refill_index : o_held.index,
    mask:  cache_pkg::line_t'(word_mask) << (word_sel * cache_pkg::WORD_W),
    data:  {cache_pkg::WORDS_PER_LINE{word_data}}
  };

endmodule

/* rtl/cache_lookup.sv */
// Tag compare and main cache FSM
module cache_lookup (
  input  logic                                            i_clk,
  input  logic                                            i_rst,
  input  logic                                            i_valid,
  input  logic                                            i_conflict,
  input  cache_pkg::cache_req_t                           i_req,
  input  logic [cache_pkg::INDEX_W-1:0]                   i_in_index,
  input  cache_pkg::tag_entry_t [cache_pkg::NUM_WAYS-1:0] i_tag_rd,
  input  cache_pkg::line_t [cache_pkg::NUM_WAYS-1:0]      i_line_rd,
  input  logic                                            i_rd_rdy,
  input  logic                                            i_ret_valid,
  input  logic                                            i_ret_last,
  input  logic [cache_pkg::WORD_W-1:0]                    i_ret_data,
  input  logic                                            i_wr_rdy,
  output logic                                            o_accept,
  output logic                                            o_addr_ok,
  output logic [cache_pkg::INDEX_W-1:0]                   o_ram_index,
  output logic [cache_pkg::NUM_WAYS-1:0]                  o_tag_we,
  output logic [cache_pkg::INDEX_W-1:0]                   o_tag_windex,
  output cache_pkg::tag_entry_t                           o_tag_wdata,
  output logic                                            o_lookup,
  output logic                                            o_hit,
  output logic                                            o_hit_way,
  output cache_pkg::store_op_t                            o_store,
  output logic                                            o_refill_en,
  output logic                                            o_refill_way,
  output logic [1:0]                                      o_refill_beat,
  output logic [cache_pkg::WORD_W-1:0]                    o_refill_data,
  output logic                                            o_rd_req,
  output logic [cache_pkg::ADDR_W-1:0]                    o_rd_addr,
  output logic                                            o_wr_req,
  output logic [cache_pkg::ADDR_W-1:0]                    o_wr_addr,
  output cache_pkg::line_t                                o_wr_data
);

  cache_pkg::cache_state_e        state_q;
  cache_pkg::cache_state_e        state_d;
  logic [cache_pkg::NUM_WAYS-1:0] way_hit;
  logic                           in_lookup;
  logic                           victim_pick;
  logic                           victim_q;
  logic                           victim_dirty;
  logic                           rr_q;            // round-robin victim
  logic [1:0]                     beat_q;
  logic                           refill_done;
  logic                           clr_busy_q;      // tag sweep after reset
  logic [cache_pkg::INDEX_W-1:0]  clr_ptr_q;

  // ----------------------------------------------------------
  // tag compare
  always_comb begin
    for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
      way_hit[w] = i_tag_rd[w].valid && (i_tag_rd[w].tag == i_req.tag);
    end
  end

  assign in_lookup = (state_q == cache_pkg::S_LOOKUP);
  assign o_lookup  = in_lookup;
  assign o_hit     = (|way_hit) && !clr_busy_q;  // no hits until tags are cleared
  assign o_hit_way = way_hit[1];

  assign o_addr_ok   = !i_conflict && ((state_q == cache_pkg::S_IDLE) || (in_lookup && o_hit));
  assign o_accept    = i_valid && o_addr_ok;
  assign o_ram_index = o_accept ? i_in_index : i_req.index;

  assign o_store = '{
    valid: in_lookup && o_hit && i_req.is_write,
    way:   o_hit_way,
    index: i_req.index,
    word:  i_req.offset[cache_pkg::OFFSET_W-1 -: 2],
    wstrb: i_req.wstrb,
    wdata: i_req.wdata
  };

  // invalid way first, then round robin
  assign victim_pick  = !i_tag_rd[0].valid ? 1'b0 :
                        !i_tag_rd[1].valid ? 1'b1 : rr_q;
  assign victim_dirty = i_tag_rd[victim_q].valid && i_tag_rd[victim_q].dirty;
  assign refill_done  = (state_q == cache_pkg::S_REFILL) && i_ret_valid && i_ret_last;

  // ----------------------------------------------------------
  // main FSM
  always_comb begin
    state_d = state_q;
    case (state_q)
      cache_pkg::S_IDLE: begin
        if (o_accept) begin
          state_d = cache_pkg::S_LOOKUP;
        end
      end
      cache_pkg::S_LOOKUP: begin
        if (clr_busy_q) begin
          state_d = cache_pkg::S_LOOKUP;           // wait for tag sweep
        end else if (!o_hit) begin
          state_d = cache_pkg::S_MISS;
        end else if (!o_accept) begin
          state_d = cache_pkg::S_IDLE;
        end
      end
      cache_pkg::S_MISS: begin
        if (!victim_dirty || i_wr_rdy) begin
          state_d = cache_pkg::S_REPLACE;
        end
      end
      cache_pkg::S_REPLACE: begin
        if (i_rd_rdy) begin
          state_d = cache_pkg::S_REFILL;
        end
      end
      cache_pkg::S_REFILL: begin
        if (refill_done) begin
          state_d = cache_pkg::S_LOOKUP;           // re-lookup completes as hit
        end
      end
      default: state_d = cache_pkg::S_IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q    <= cache_pkg::S_IDLE;
      victim_q   <= 1'b0;
      rr_q       <= 1'b0;
      beat_q     <= '0;
      clr_busy_q <= 1'b1;
      clr_ptr_q  <= '0;
    end else begin
      state_q <= state_d;
      if (in_lookup) begin
        victim_q <= victim_pick;
      end
      if (refill_done) begin
        rr_q <= ~rr_q;
      end
      if (state_q == cache_pkg::S_REPLACE) begin
        beat_q <= '0;
      end else if (o_refill_en) begin
        beat_q <= beat_q + 2'd1;
      end
      if (clr_busy_q) begin
        clr_ptr_q <= clr_ptr_q + 1'b1;
        if (&clr_ptr_q) begin
          clr_busy_q <= 1'b0;
        end
      end
    end
  end

  // ----------------------------------------------------------
  // tag writes: sweep, refill, store dirty
  always_comb begin
    o_tag_we     = '0;
    o_tag_windex = i_req.index;
    o_tag_wdata  = '{valid: 1'b1, dirty: in_lookup, tag: i_req.tag};
    if (clr_busy_q) begin
      o_tag_we     = '1;
      o_tag_windex = clr_ptr_q;
      o_tag_wdata  = '0;
    end else if (refill_done) begin
      o_tag_we[victim_q] = 1'b1;
    end else if (o_store.valid) begin
      o_tag_we[o_hit_way] = 1'b1;
    end
  end

  // ----------------------------------------------------------
  // memory bus
  assign o_refill_en   = (state_q == cache_pkg::S_REFILL) && i_ret_valid;
  assign o_refill_way  = victim_q;
  assign o_refill_beat = beat_q;
  assign o_refill_data = i_ret_data;

  assign o_rd_req  = (state_q == cache_pkg::S_REPLACE);
  assign o_rd_addr = {i_req.tag, i_req.index, {cache_pkg::OFFSET_W{1'b0}}};
  assign o_wr_req  = (state_q == cache_pkg::S_MISS) && victim_dirty && i_wr_rdy;
  assign o_wr_addr = {i_tag_rd[victim_q].tag, i_req.index, {cache_pkg::OFFSET_W{1'b0}}};
  assign o_wr_data = i_line_rd[victim_q];

endmodule

/* rtl/cache_req_decode.sv */
// CPU request decode and buffer
module cache_req_decode (
  input  logic                         i_clk,
  input  logic                         i_rst,
  input  logic                         i_valid,
  input  logic                         i_op,          // 1 write, 0 read
  input  logic [cache_pkg::ADDR_W-1:0] i_addr,
  input  logic [cache_pkg::STRB_W-1:0] i_wstrb,
  input  logic [cache_pkg::WORD_W-1:0] i_wdata,
  input  logic                         i_accept,
  input  cache_pkg::store_op_t         i_store_held,
  input  cache_pkg::store_op_t         i_store_now,
  output logic                         o_conflict,
  output cache_pkg::cache_req_t        o_req
);

  cache_pkg::cache_req_t         in_req;
  logic [1:0]                    in_word;
  logic                          hit_held;
  logic                          hit_now;

  assign in_req = '{
    is_write: i_op,
    tag:      i_addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W],
    index:    i_addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W],
    offset:   i_addr[cache_pkg::OFFSET_W-1:0],
    wstrb:    i_wstrb,
    wdata:    i_wdata
  };
  assign in_word = in_req.offset[cache_pkg::OFFSET_W-1 -: 2];

  // read-after-write hazard on the same word
  assign hit_held = i_store_held.valid && (i_store_held.index == in_req.index) &&
                    (i_store_held.word == in_word);
  assign hit_now  = i_store_now.valid && (i_store_now.index == in_req.index) &&
                    (i_store_now.word == in_word);
  assign o_conflict = i_valid && (hit_held || hit_now);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_req <= '0;
    end else if (i_accept) begin
      o_req <= in_req;
    end
  end

endmodule

/* rtl/cache_way_ram.sv */
// Single cache way storage
module cache_way_ram #(
  parameter type ENTRY_T = logic [7:0],
  parameter int  DEPTH   = 64
) (
  input  logic                     i_clk,
  input  logic                     i_we,
  input  logic [$clog2(DEPTH)-1:0] i_waddr,
  input  logic [$clog2(DEPTH)-1:0] i_addr,  // read address
  input  ENTRY_T                   i_wmask,
  input  ENTRY_T                   i_wdata,
  output ENTRY_T                   o_rdata
);

  ENTRY_T mem [DEPTH];
  ENTRY_T wr_merged;

  // keep unmasked bits of the stored entry
  assign wr_merged = ENTRY_T'((mem[i_waddr] & ~i_wmask) | (i_wdata & i_wmask));

  always_ff @(posedge i_clk) begin
    if (i_we) begin
      mem[i_waddr] <= wr_merged;
    end
    if (i_we && (i_waddr == i_addr)) begin
      o_rdata <= wr_merged;                 // write-first
    end else begin
      o_rdata <= mem[i_addr];
    end
  end

endmodule

/* rtl/cache_pkg.sv */
// Data cache shared definitions
package cache_pkg;

  // ----------------------------------------------------------
  // geometry
  localparam int ADDR_W         = 32;
  localparam int WORD_W         = 64;
  localparam int STRB_W         = WORD_W / 8;
  localparam int OFFSET_W       = 5;             // 32-byte line
  localparam int INDEX_W        = 6;
  localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W;
  localparam int NUM_SETS       = 1 << INDEX_W;
  localparam int NUM_WAYS       = 2;
  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_W         = WORD_W * WORDS_PER_LINE;

  typedef logic [LINE_W-1:0] line_t;

  typedef struct packed {
    logic             valid;
    logic             dirty;
    logic [TAG_W-1:0] tag;
  } tag_entry_t;

  typedef struct packed {
    logic                is_write;
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
    logic [STRB_W-1:0]   wstrb;             // active high
    logic [WORD_W-1:0]   wdata;
  } cache_req_t;

  typedef struct packed {
    logic               valid;
    logic               way;
    logic [INDEX_W-1:0] index;
    logic [1:0]         word;               // word within line
    logic [STRB_W-1:0]  wstrb;
    logic [WORD_W-1:0]  wdata;
  } store_op_t;

  typedef struct packed {
    logic               en;
    logic               way;
    logic [INDEX_W-1:0] index;
    line_t              mask;               // bit-level write mask
    line_t              data;
  } line_wr_t;

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOOKUP,
    S_MISS,
    S_REPLACE,
    S_REFILL
  } cache_state_e;

endpackage
